/* verilog/img_pkg.sv */
package img_pkg;

    // frame geometry
    localparam int h_res        = 8;
    localparam int v_res        = 4;
    localparam int frame_pixels = h_res * v_res;
    localparam int addr_w       = $clog2(frame_pixels);
    localparam int x_w          = $clog2(h_res);
    localparam int y_w          = $clog2(v_res);

    // serial line timing
    localparam int clks_per_bit = 8;
    localparam int baud_w       = $clog2(clks_per_bit);

    // hysteresis levels on the gray value
    localparam int th_high = 160;
    localparam int th_low  = 96;

    // the output FIFO holds a whole frame
    localparam int fifo_depth  = frame_pixels;
    localparam int fifo_addr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w  = $clog2(fifo_depth + 1);

    typedef logic [addr_w-1:0] pix_addr_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic      en;
        pix_addr_t addr;
        pixel_t    data;
    } ram_wr_t;

endpackage

/* verilog/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_rx,
    output logic [7:0] o_byte,
    output logic       o_valid
);
    import img_pkg::*;

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_t;

    rx_state_t         state;
    logic              rx_meta;
    logic              rx_sync;
    logic              rx_last;
    logic [baud_w-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        shift;
    logic              half_tick;
    logic              full_tick;

    assign half_tick = baud_cnt == baud_w'(clks_per_bit / 2 - 1);
    assign full_tick = baud_cnt == baud_w'(clks_per_bit - 1);

    // two flops against metastability, a third one to see the falling edge
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            o_valid  <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                st_idle: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (rx_last && !rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // half a bit in, the start bit must still be low
                    if (half_tick) begin
                        baud_cnt <= '0;
                        state    <= rx_sync ? st_idle : st_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (full_tick) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (full_tick) begin
                        o_valid <= rx_sync;
                        state   <= st_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // data arrives lsb first
    always_ff @(posedge clk) begin
        if (state == st_data && full_tick) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign o_byte = shift;

endmodule

/* verilog/pixel_assembler.sv */
`timescale 1ns/1ps

module pixel_assembler (
    input  logic             clk,
    input  logic             reset,
    input  logic [7:0]       i_byte,
    input  logic             i_valid,
    output img_pkg::ram_wr_t o_wr,
    output logic             o_frame_done
);
    import img_pkg::*;

    logic [1:0] phase;
    logic [7:0] r_hold;
    logic [7:0] g_hold;
    pix_addr_t  pix_cnt;
    logic       last_pix;
    logic       wr_en;
    pix_addr_t  wr_addr;
    pixel_t     wr_data;

    assign last_pix = pix_cnt == pix_addr_t'(frame_pixels - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= '0;
            pix_cnt      <= '0;
            wr_en        <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            wr_en        <= 1'b0;
            o_frame_done <= 1'b0;
            if (i_valid) begin
                if (phase == 2'd2) begin
                    phase        <= '0;
                    wr_en        <= 1'b1;
                    o_frame_done <= last_pix;
                    pix_cnt      <= last_pix ? '0 : pix_cnt + 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    // bytes come in as r, g, b
    always_ff @(posedge clk) begin
        if (i_valid) begin
            case (phase)
                2'd0: r_hold <= i_byte;
                2'd1: g_hold <= i_byte;
                default: begin
                    wr_data <= '{r: r_hold, g: g_hold, b: i_byte};
                    wr_addr <= pix_cnt;
                end
            endcase
        end
    end

    always_comb begin
        o_wr.en   = wr_en;
        o_wr.addr = wr_addr;
        o_wr.data = wr_data;
    end

    // received bytes are a whole serial frame apart so none lands on a write strobe
    a_wr_no_new_byte: assert property (@(posedge clk) disable iff (reset)
        o_wr.en |-> !i_valid)
        else $error("received byte collided with a pixel write");

endmodule

/* verilog/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram (
    input  logic               clk,
    input  logic               reset,
    input  img_pkg::ram_wr_t   i_wr,
    input  logic               i_frame_done,
    input  img_pkg::pix_addr_t i_raddr,
    input  logic               i_re,
    output img_pkg::pixel_t    o_rdata,
    output logic               o_frame_done
);
    import img_pkg::*;

    pixel_t mem [frame_pixels];

    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            mem[i_wr.addr] <= i_wr.data;
        end
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

    // one cycle late so the reader cannot overtake the last write
    always_ff @(posedge clk) begin
        if (reset) begin
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= i_frame_done;
        end
    end

    a_waddr_in_frame: assert property (@(posedge clk) disable iff (reset)
        i_wr.en |-> int'(i_wr.addr) < frame_pixels)
        else $error("frame RAM write address outside the frame");

endmodule

/* verilog/img_reader.sv */
`timescale 1ns/1ps

module img_reader (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_start,
    input  img_pkg::pixel_t    i_rdata,
    output img_pkg::pix_addr_t o_raddr,
    output logic               o_re,
    output img_pkg::pixel_t    o_pix,
    output logic               o_de
);
    import img_pkg::*;

    logic [x_w-1:0] x_cnt;
    logic [y_w-1:0] y_cnt;
    logic           reading;
    logic           last_pos;

    assign last_pos = x_cnt == x_w'(h_res - 1) && y_cnt == y_w'(v_res - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            reading <= 1'b0;
        end else if (i_start) begin
            reading <= 1'b1;
        end else if (reading && last_pos) begin
            reading <= 1'b0;
        end
    end

    // raster scan, x runs fastest
    always_ff @(posedge clk) begin
        if (reset || !reading) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == x_w'(h_res - 1)) begin
            x_cnt <= '0;
            y_cnt <= (y_cnt == y_w'(v_res - 1)) ? '0 : y_cnt + 1'b1;
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_re <= 1'b0;
            o_de <= 1'b0;
        end else begin
            o_re <= reading;
            o_de <= o_re;
        end
    end

    // address is registered together with the read enable
    always_ff @(posedge clk) begin
        o_raddr <= pix_addr_t'(y_cnt) * pix_addr_t'(h_res) + pix_addr_t'(x_cnt);
    end

    assign o_pix = o_de ? i_rdata : '0;

    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        i_start |-> !reading)
        else $error("new frame started while the previous one is still being read");

endmodule

/* verilog/edge_filter.sv */
`timescale 1ns/1ps

module edge_filter (
    input  logic            clk,
    input  logic            reset,
    input  img_pkg::pixel_t i_pix,
    input  logic            i_de,
    output logic [7:0]      o_data,
    output logic            o_de
);
    import img_pkg::*;

    logic [9:0]     gray_sum;
    logic [7:0]     gray;
    logic [x_w-1:0] col;
    logic [7:0]     last_out;
    logic [7:0]     prev_out;
    logic [7:0]     next_out;

    always_comb begin
        // weights 1, 2, 1 over four
        gray_sum = 10'(i_pix.r) + 10'({i_pix.g, 1'b0}) + 10'(i_pix.b);
        gray     = gray_sum[9:2];
        // hysteresis memory restarts at 0 at every row start
        prev_out = (col == '0) ? 8'd0 : last_out;
        if (gray >= 8'(th_high)) begin
            next_out = 8'hff;
        end else if (gray < 8'(th_low)) begin
            next_out = 8'h00;
        end else begin
            next_out = prev_out;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            col      <= '0;
            last_out <= '0;
            o_de     <= 1'b0;
        end else begin
            o_de <= i_de;
            if (i_de) begin
                col      <= (col == x_w'(h_res - 1)) ? '0 : col + 1'b1;
                last_out <= next_out;
            end
        end
    end

    assign o_data = last_out;

endmodule

/* verilog/uart_tx_path.sv */
`timescale 1ns/1ps

module uart_tx_path (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] i_data,
    input  logic       i_de,
    output logic       o_tx
);
    import img_pkg::*;

    logic [7:0]             fifo_mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0]  count;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   push;
    logic                   pop;
    logic                   busy;
    logic [baud_w-1:0]      baud_cnt;
    logic [3:0]             bit_idx;
    logic [9:0]             tx_shift;
    logic                   bit_tick;
    logic                   frame_end;

    assign fifo_full  = count == fifo_cnt_w'(fifo_depth);
    assign fifo_empty = count == '0;
    assign push       = i_de && !fifo_full;
    assign bit_tick   = busy && baud_cnt == baud_w'(clks_per_bit - 1);
    assign frame_end  = bit_tick && bit_idx == 4'd9;
    // the next byte loads in the last stop-bit cycle, so bytes go out back to back
    assign pop        = !fifo_empty && (!busy || frame_end);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_addr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fifo_addr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // stop, data and start bits, shifted out from bit 0
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_shift <= '1;
        end else if (pop) begin
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_shift <= {1'b1, fifo_mem[rd_ptr], 1'b0};
        end else if (bit_tick) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            tx_shift <= {1'b1, tx_shift[9:1]};
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end
        end else if (busy) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign o_tx = tx_shift[0];

    // nothing upstream can stall, so a full FIFO here means a lost byte
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        i_de |-> !fifo_full)
        else $error("filtered byte pushed into a full transmit FIFO");

endmodule

/* verilog/img_uart_top.sv */
`timescale 1ns/1ps

module img_uart_top (
    input  logic clk,
    input  logic reset,
    input  logic i_rx,
    output logic o_tx
);
    import img_pkg::*;

    logic       rx_valid;
    logic [7:0] rx_byte;
    ram_wr_t    ram_wr;
    logic       asm_frame_done;
    logic       ram_frame_done;
    pix_addr_t  rd_addr;
    logic       rd_en;
    pixel_t     rd_data;
    pixel_t     rd_pix;
    logic       rd_de;
    logic [7:0] filt_data;
    logic       filt_de;

    uart_rx u_uart_rx (
        .clk     (clk),
        .reset   (reset),
        .i_rx    (i_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    pixel_assembler u_pixel_assembler (
        .clk          (clk),
        .reset        (reset),
        .i_byte       (rx_byte),
        .i_valid      (rx_valid),
        .o_wr         (ram_wr),
        .o_frame_done (asm_frame_done)
    );

    frame_ram u_frame_ram (
        .clk          (clk),
        .reset        (reset),
        .i_wr         (ram_wr),
        .i_frame_done (asm_frame_done),
        .i_raddr      (rd_addr),
        .i_re         (rd_en),
        .o_rdata      (rd_data),
        .o_frame_done (ram_frame_done)
    );

    img_reader u_img_reader (
        .clk     (clk),
        .reset   (reset),
        .i_start (ram_frame_done),
        .i_rdata (rd_data),
        .o_raddr (rd_addr),
        .o_re    (rd_en),
        .o_pix   (rd_pix),
        .o_de    (rd_de)
    );

    edge_filter u_edge_filter (
        .clk    (clk),
        .reset  (reset),
        .i_pix  (rd_pix),
        .i_de   (rd_de),
        .o_data (filt_data),
        .o_de   (filt_de)
    );

    uart_tx_path u_uart_tx_path (
        .clk    (clk),
        .reset  (reset),
        .i_data (filt_data),
        .i_de   (filt_de),
        .o_tx   (o_tx)
    );

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk,
    output logic o_reset
);
    localparam real half_period = 2.0;

    initial begin
        o_clk = 1'b0;
        forever #(half_period) o_clk = ~o_clk;
    end

    // reset spans three rising edges and drops on a falling edge
    initial begin
        o_reset = 1'b1;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

/* dv/tb_img_uart.sv */
`timescale 1ns/1ps

module tb_img_uart;
    import img_pkg::*;

    localparam int byte_clks   = 10 * clks_per_bit;
    localparam int start_limit = 4 * frame_pixels * byte_clks;
    localparam int idle_clks   = 3 * byte_clks;
    localparam int reset_limit = 20;

    logic       clk;
    logic       reset;
    logic       rx;
    logic       tx;
    int         seed = 11;
    int         errors;
    int         tests_run;
    int         tests_failed;
    pixel_t     frame [frame_pixels];
    logic [7:0] received [frame_pixels];
    logic [7:0] exp_q [$];

    tb_clock clock0 (
        .o_clk   (clk),
        .o_reset (reset)
    );

    img_uart_top dut0 (
        .clk   (clk),
        .reset (reset),
        .i_rx  (rx),
        .o_tx  (tx)
    );

    function automatic int gray_of(pixel_t p);
        return (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
    endfunction

    // expected bytes in raster order, hysteresis state cleared at each row start
    task automatic build_model();
        logic [7:0] prev;
        int         gray;
        prev = 8'h00;
        exp_q.delete();
        for (int i = 0; i < frame_pixels; i++) begin
            if (i % h_res == 0) begin
                prev = 8'h00;
            end
            gray = gray_of(frame[i]);
            if (gray >= th_high) begin
                prev = 8'hff;
            end else if (gray < th_low) begin
                prev = 8'h00;
            end
            exp_q.push_back(prev);
        end
    endtask

    task automatic random_pixel(output pixel_t p);
        logic [31:0] rnd;
        rnd = $random(seed);
        p = rnd[23:0];
    endtask

    task automatic fill_random_frame();
        for (int i = 0; i < frame_pixels; i++) begin
            random_pixel(frame[i]);
        end
    endtask

    // row 0 steps high, middle, low, middle and ends high so row 1 opens on a middle value
    task automatic fill_fixed_frame();
        fill_random_frame();
        frame[0]         = '{r: 8'd200, g: 8'd200, b: 8'd200};
        frame[1]         = '{r: 8'd128, g: 8'd128, b: 8'd128};
        frame[2]         = '{r: 8'd40, g: 8'd40, b: 8'd40};
        frame[3]         = '{r: 8'd128, g: 8'd128, b: 8'd128};
        frame[h_res - 1] = '{r: 8'd200, g: 8'd200, b: 8'd200};
        frame[h_res]     = '{r: 8'd120, g: 8'd130, b: 8'd140};
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx = bits[i];
            repeat (clks_per_bit - 1) @(negedge clk);
        end
    endtask

    task automatic send_frame();
        for (int i = 0; i < frame_pixels; i++) begin
            send_byte(frame[i].r);
            send_byte(frame[i].g);
            send_byte(frame[i].b);
        end
    endtask

    task automatic receive_byte(input int index, output logic [7:0] data);
        int wait_cnt;
        wait_cnt = 0;
        data = 8'h00;
        while (tx !== 1'b0 && wait_cnt < start_limit) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (wait_cnt >= start_limit) begin
            $display("timeout waiting for the start bit of output byte %0d", index);
            $display("Simulation failed");
            $finish;
        end else begin
            // move to the middle of the start bit
            repeat (clks_per_bit / 2) @(negedge clk);
            assert (tx === 1'b0) else begin
                $display("start bit of output byte %0d did not stay low", index);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                data[i] = tx;
            end
            repeat (clks_per_bit) @(negedge clk);
            assert (tx === 1'b1) else begin
                $display("stop bit of output byte %0d was not high", index);
                errors++;
            end
        end
    endtask

    task automatic receive_frame();
        logic [7:0] got;
        for (int i = 0; i < frame_pixels; i++) begin
            receive_byte(i, got);
            received[i] = got;
        end
    endtask

    task automatic check_idle(input int cycles, input string what);
        int lows;
        lows = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                lows++;
            end
        end
        assert (lows == 0) else begin
            $display("o_tx was not idle for %0d of %0d cycles %s", lows, cycles, what);
            errors++;
        end
    endtask

    task automatic check_byte(input int index, input logic [7:0] exp);
        assert (received[index] === exp) else begin
            $display("Fail o_tx_byte[%0d] expected 0x%02h received 0x%02h",
                     index, exp, received[index]);
            errors++;
        end
    endtask

    task automatic check_frame_values();
        for (int i = 0; i < frame_pixels; i++) begin
            check_byte(i, exp_q.pop_front());
        end
    endtask

    task automatic run_frame();
        build_model();
        fork
            send_frame();
            receive_frame();
        join
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic wait_reset_release();
        int wait_cnt;
        wait_cnt = 0;
        while (reset !== 1'b0 && wait_cnt < reset_limit) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (wait_cnt >= reset_limit) begin
            $display("timeout waiting for reset to be released");
            $display("Simulation failed");
            $finish;
        end
    endtask

    initial begin
        int mark;
        rx           = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        wait_reset_release();

        mark = errors;
        check_idle(idle_clks, "after reset");
        finish_test("idle_after_reset", mark);

        fill_fixed_frame();
        mark = errors;
        run_frame();
        check_idle(idle_clks, "after the first frame");
        finish_test("byte_count_and_framing", mark);

        mark = errors;
        check_frame_values();
        finish_test("model_match", mark);

        mark = errors;
        check_byte(0, 8'hff);
        check_byte(1, 8'hff);
        check_byte(2, 8'h00);
        check_byte(3, 8'h00);
        check_byte(h_res, 8'h00);
        finish_test("hysteresis_row", mark);

        fill_random_frame();
        mark = errors;
        run_frame();
        check_frame_values();
        check_idle(idle_clks, "after the second frame");
        finish_test("second_random_frame", mark);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/img_pkg.sv
verilog/uart_rx.sv
verilog/pixel_assembler.sv
verilog/frame_ram.sv
verilog/img_reader.sv
verilog/edge_filter.sv
verilog/uart_tx_path.sv
verilog/img_uart_top.sv
dv/tb_clock.sv
dv/tb_img_uart.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_img_uart
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
